/* common/cpu_pkg.sv */
// ---------------------------------------
// CPU package
// Bus widths, vectors, opcodes, FSM state
// indices and the shared core types
// ---------------------------------------

package cpu_pkg;

  localparam int addr_w = 16;
  localparam int data_w = 8;

  localparam logic [addr_w-1:0] reset_vec_lo = 16'hfffc;
  localparam logic [addr_w-1:0] reset_vec_hi = 16'hfffd;

  // ---------------------------------------
  // Opcodes kept by this core
  // ---------------------------------------
  localparam logic [data_w-1:0] op_lda_imm = 8'ha9;
  localparam logic [data_w-1:0] op_ldx_imm = 8'ha2;
  localparam logic [data_w-1:0] op_ldy_imm = 8'ha0;
  localparam logic [data_w-1:0] op_lda_abs = 8'had;
  localparam logic [data_w-1:0] op_ldx_abs = 8'hae;
  localparam logic [data_w-1:0] op_ldy_abs = 8'hac;
  localparam logic [data_w-1:0] op_sta_abs = 8'h8d;
  localparam logic [data_w-1:0] op_stx_abs = 8'h8e;
  localparam logic [data_w-1:0] op_sty_abs = 8'h8c;
  localparam logic [data_w-1:0] op_adc_abs = 8'h6d;
  localparam logic [data_w-1:0] op_and_abs = 8'h2d;
  localparam logic [data_w-1:0] op_ora_abs = 8'h0d;
  localparam logic [data_w-1:0] op_eor_abs = 8'h4d;
  localparam logic [data_w-1:0] op_jmp_abs = 8'h4c;
  localparam logic [data_w-1:0] op_clc     = 8'h18;
  localparam logic [data_w-1:0] op_sec     = 8'h38;
  localparam logic [data_w-1:0] op_nop     = 8'hea;

  // One-hot state bit positions
  localparam int st_reset    = 0;
  localparam int st_vector_1 = 1;
  localparam int st_vector_2 = 2;
  localparam int st_fetch    = 3;
  localparam int st_decode   = 4;
  localparam int st_abs_1    = 5;
  localparam int st_abs_2    = 6;
  localparam int st_halt     = 7;
  localparam int num_states  = 8;

  // ---------------------------------------
  // Decode fields
  // ---------------------------------------
  typedef enum logic [2:0] {
    mode_imp,
    mode_imm,
    mode_abs_rd,
    mode_abs_wr,
    mode_jmp,
    mode_bad
  } addr_mode_e;

  // Carry class values are kept apart from the CLC/SEC opcode names
  typedef enum logic [2:0] {
    op_none,
    op_load,
    op_store,
    op_alu,
    op_clr_carry,
    op_set_carry
  } op_class_e;

  typedef enum logic [1:0] {
    reg_a,
    reg_x,
    reg_y
  } reg_sel_e;

  typedef enum logic [1:0] {
    alu_add,
    alu_and,
    alu_or,
    alu_xor
  } alu_op_e;

  typedef struct packed {
    addr_mode_e mode;
    op_class_e  op_class;
    reg_sel_e   reg_sel;
    alu_op_e    alu_op;
  } decode_t;

  typedef struct packed {
    logic [addr_w-1:0] address;
    logic [data_w-1:0] wr_data;
    logic              wr_enable;
  } mem_req_t;

  typedef struct packed {
    logic [data_w-1:0] result;
    logic              carry;
  } alu_out_t;

endpackage

/* src/alu.sv */
// ---------------------------------------
// ALU
// 8-bit add with carry, AND, OR and XOR
// ---------------------------------------

module alu (
  input  cpu_pkg::alu_op_e           alu_op,
  input  logic [cpu_pkg::data_w-1:0] alu_a,
  input  logic [cpu_pkg::data_w-1:0] alu_b,
  input  logic                       carry_in,
  output cpu_pkg::alu_out_t          res
);
  import cpu_pkg::*;

  logic [data_w:0] sum;

  // One extra bit catches the carry out
  assign sum = {1'b0, alu_a} + {1'b0, alu_b} + {{data_w{1'b0}}, carry_in};

  always_comb begin
    // Logic ops pass the carry through
    res.carry = carry_in;
    case (alu_op)
      alu_add: begin
        res.result = sum[data_w-1:0];
        res.carry  = sum[data_w];
      end
      alu_and: res.result = alu_a & alu_b;
      alu_or:  res.result = alu_a | alu_b;
      default: res.result = alu_a ^ alu_b;
    endcase
  end

endmodule

/* core/opcode_decoder.sv */
// ---------------------------------------
// Opcode decoder
// Maps the instruction register to an
// addressing mode and operation class
// ---------------------------------------

module opcode_decoder (
  input  logic [cpu_pkg::data_w-1:0] ir,
  output cpu_pkg::decode_t           dec
);
  import cpu_pkg::*;

  always_comb begin
    // Anything not listed stops the core
    dec = '{mode_bad, op_none, reg_a, alu_add};

    case (ir)
      // Implied
      op_clc: dec = '{mode_imp, op_clr_carry, reg_a, alu_add};
      op_sec: dec = '{mode_imp, op_set_carry, reg_a, alu_add};
      op_nop: dec = '{mode_imp, op_none, reg_a, alu_add};

      // Immediate loads
      op_lda_imm: dec = '{mode_imm, op_load, reg_a, alu_add};
      op_ldx_imm: dec = '{mode_imm, op_load, reg_x, alu_add};
      op_ldy_imm: dec = '{mode_imm, op_load, reg_y, alu_add};

      // Absolute loads
      op_lda_abs: dec = '{mode_abs_rd, op_load, reg_a, alu_add};
      op_ldx_abs: dec = '{mode_abs_rd, op_load, reg_x, alu_add};
      op_ldy_abs: dec = '{mode_abs_rd, op_load, reg_y, alu_add};

      // Absolute stores
      op_sta_abs: dec = '{mode_abs_wr, op_store, reg_a, alu_add};
      op_stx_abs: dec = '{mode_abs_wr, op_store, reg_x, alu_add};
      op_sty_abs: dec = '{mode_abs_wr, op_store, reg_y, alu_add};

      // Accumulator ALU ops with a memory operand
      op_adc_abs: dec = '{mode_abs_rd, op_alu, reg_a, alu_add};
      op_and_abs: dec = '{mode_abs_rd, op_alu, reg_a, alu_and};
      op_ora_abs: dec = '{mode_abs_rd, op_alu, reg_a, alu_or};
      op_eor_abs: dec = '{mode_abs_rd, op_alu, reg_a, alu_xor};

      op_jmp_abs: dec = '{mode_jmp, op_none, reg_a, alu_add};

      default: ;
    endcase
  end

endmodule

/* core/reg_bank.sv */
// ---------------------------------------
// Register bank
// A, X, Y and carry, with ALU results
// written back during the next fetch
// ---------------------------------------

module reg_bank (
  input  logic                       clk,
  input  logic                       resetn,
  input  logic [cpu_pkg::data_w-1:0] rd_data,
  input  cpu_pkg::decode_t           dec,
  input  logic                       exec,
  input  logic                       fetch,
  input  cpu_pkg::alu_out_t          alu_res,
  output logic [cpu_pkg::data_w-1:0] alu_a,
  output logic [cpu_pkg::data_w-1:0] alu_b,
  output logic                       carry_in,
  output cpu_pkg::alu_op_e           alu_op,
  output logic [cpu_pkg::data_w-1:0] store_data
);
  import cpu_pkg::*;

  logic [data_w-1:0] a;
  logic [data_w-1:0] x;
  logic [data_w-1:0] y;
  logic              carry;
  logic              pending;
  logic              load_en;

  assign carry_in = carry;
  assign load_en  = exec && (dec.op_class == op_load);

  always_comb begin
    case (dec.reg_sel)
      reg_x:   store_data = x;
      reg_y:   store_data = y;
      default: store_data = a;
    endcase
  end

  // Accumulator and ALU operand latches
  always_ff @(posedge clk) begin
    if (load_en && dec.reg_sel == reg_a) begin
      a <= rd_data;
    end else if (fetch && pending) begin
      a <= alu_res.result;
    end
    if (exec && dec.op_class == op_alu) begin
      alu_a  <= a;
      alu_b  <= rd_data;
      alu_op <= dec.alu_op;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      x       <= '0;
      y       <= '0;
      carry   <= 1'b0;
      pending <= 1'b0;
    end else if (exec) begin
      case (dec.op_class)
        op_load: begin
          if (dec.reg_sel == reg_x) x <= rd_data;
          if (dec.reg_sel == reg_y) y <= rd_data;
        end
        op_alu:       pending <= 1'b1;
        op_clr_carry: carry <= 1'b0;
        op_set_carry: carry <= 1'b1;
        default: ;
      endcase
    end else if (fetch && pending) begin
      pending <= 1'b0;
      // Only an add produces a new carry
      if (alu_op == alu_add) carry <= alu_res.carry;
    end
  end

  // Write-back relies on the sequencer never overlapping the two strobes
  no_exec_on_fetch: assert property (@(posedge clk) disable iff (!resetn)
    !(exec && fetch));

endmodule

/* core/sequencer.sv */
// ---------------------------------------
// Sequencer
// One-hot instruction FSM that owns PC,
// IR, the operand latch and the bus
// ---------------------------------------

module sequencer (
  input  logic                       clk,
  input  logic                       resetn,
  input  logic [cpu_pkg::data_w-1:0] rd_data,
  input  cpu_pkg::decode_t           dec,
  input  logic [cpu_pkg::data_w-1:0] store_data,
  output logic [cpu_pkg::data_w-1:0] ir,
  output logic                       exec,
  output logic                       fetch,
  output cpu_pkg::mem_req_t          mem_req
);
  import cpu_pkg::*;

  logic [num_states-1:0] state;
  logic [num_states-1:0] state_nxt;
  logic [addr_w-1:0]     pc;
  logic [data_w-1:0]     operand_lo;
  logic [addr_w-1:0]     abs_addr;
  logic                  mode_short;

  // High byte arrives on the bus, low byte was latched in DECODE
  assign abs_addr   = {rd_data, operand_lo};
  assign mode_short = (dec.mode == mode_imp) || (dec.mode == mode_imm);

  assign fetch = state[st_fetch];
  assign exec  = (state[st_decode] && mode_short) ||
                 (state[st_abs_2] && dec.mode == mode_abs_rd);

  // ---------------------------------------
  // Next state
  // ---------------------------------------
  always_comb begin
    state_nxt = '0;
    case (1'b1)
      state[st_reset]:    state_nxt[st_vector_1] = 1'b1;
      state[st_vector_1]: state_nxt[st_vector_2] = 1'b1;
      state[st_vector_2]: state_nxt[st_fetch] = 1'b1;
      state[st_fetch]:    state_nxt[st_decode] = 1'b1;
      state[st_decode]: begin
        if (mode_short) state_nxt[st_fetch] = 1'b1;
        else if (dec.mode == mode_bad) state_nxt[st_halt] = 1'b1;
        else state_nxt[st_abs_1] = 1'b1;
      end
      state[st_abs_1]: begin
        if (dec.mode == mode_jmp) state_nxt[st_fetch] = 1'b1;
        else state_nxt[st_abs_2] = 1'b1;
      end
      state[st_abs_2]:    state_nxt[st_fetch] = 1'b1;
      // HALT and any broken encoding
      default:            state_nxt[st_halt] = 1'b1;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= '0;
      state[st_reset] <= 1'b1;
    end else begin
      state <= state_nxt;
    end
  end

  // ---------------------------------------
  // PC, IR and operand latch
  // ---------------------------------------
  always_ff @(posedge clk) begin
    case (1'b1)
      state[st_vector_1]: pc[data_w-1:0] <= rd_data;
      state[st_vector_2]: pc[addr_w-1:data_w] <= rd_data;
      state[st_fetch]:    ir <= rd_data;
      state[st_decode]: begin
        operand_lo <= rd_data;
        if (dec.mode == mode_imp) pc <= pc + addr_w'(1);
        if (dec.mode == mode_imm) pc <= pc + addr_w'(2);
      end
      state[st_abs_1]: begin
        if (dec.mode == mode_jmp) pc <= abs_addr;
      end
      state[st_abs_2]:    pc <= pc + addr_w'(3);
      default: ;
    endcase
  end

  // ---------------------------------------
  // Registered memory request
  // ---------------------------------------
  always_ff @(posedge clk) begin
    if (!resetn) begin
      mem_req <= '{address: reset_vec_lo, wr_data: '0, wr_enable: 1'b0};
    end else begin
      case (1'b1)
        state[st_vector_1]: mem_req.address <= reset_vec_hi;
        state[st_vector_2]: mem_req.address <= {rd_data, pc[data_w-1:0]};
        state[st_fetch]:    mem_req.address <= pc + addr_w'(1);
        state[st_decode]: begin
          // Illegal opcode leaves the address where it is
          if (dec.mode == mode_imp) mem_req.address <= pc + addr_w'(1);
          else if (dec.mode != mode_bad) mem_req.address <= pc + addr_w'(2);
        end
        state[st_abs_1]: begin
          mem_req.address <= abs_addr;
          if (dec.mode == mode_abs_wr) begin
            mem_req.wr_data   <= store_data;
            mem_req.wr_enable <= 1'b1;
          end
        end
        state[st_abs_2]: begin
          mem_req.address   <= pc + addr_w'(3);
          mem_req.wr_enable <= 1'b0;
        end
        default: ;
      endcase
    end
  end

  state_onehot: assert property (@(posedge clk) disable iff (!resetn)
    $onehot(state));

  // Stores drive the bus only during their data cycle
  wr_only_abs_2: assert property (@(posedge clk) disable iff (!resetn)
    mem_req.wr_enable |-> state[st_abs_2]);

endmodule

/* src/cpu_top.sv */
// ---------------------------------------
// CPU top
// Connects sequencer, decoder, register
// bank and ALU to the memory bus
// ---------------------------------------

module cpu_top (
  input  logic                       clk,
  input  logic                       resetn,
  input  logic [cpu_pkg::data_w-1:0] rd_data,
  output cpu_pkg::mem_req_t          mem_req
);
  import cpu_pkg::*;

  logic [data_w-1:0] ir;
  decode_t           dec;
  logic              exec;
  logic              fetch;
  logic [data_w-1:0] store_data;
  logic [data_w-1:0] alu_a;
  logic [data_w-1:0] alu_b;
  logic              carry_in;
  alu_op_e           alu_op;
  alu_out_t          alu_res;

  sequencer u_sequencer (
    .clk        (clk),
    .resetn     (resetn),
    .rd_data    (rd_data),
    .dec        (dec),
    .store_data (store_data),
    .ir         (ir),
    .exec       (exec),
    .fetch      (fetch),
    .mem_req    (mem_req)
  );

  opcode_decoder u_decoder (
    .ir  (ir),
    .dec (dec)
  );

  reg_bank u_reg_bank (
    .clk        (clk),
    .resetn     (resetn),
    .rd_data    (rd_data),
    .dec        (dec),
    .exec       (exec),
    .fetch      (fetch),
    .alu_res    (alu_res),
    .alu_a      (alu_a),
    .alu_b      (alu_b),
    .carry_in   (carry_in),
    .alu_op     (alu_op),
    .store_data (store_data)
  );

  alu u_alu (
    .alu_op   (alu_op),
    .alu_a    (alu_a),
    .alu_b    (alu_b),
    .carry_in (carry_in),
    .res      (alu_res)
  );

endmodule

/* verif/tb_mem.sv */
// ---------------------------------------
// Testbench memory
// 64 KB with asynchronous read, a program
// load port and a log of core writes
// ---------------------------------------

module tb_mem (
  input  logic                       clk,
  input  logic                       clear,
  input  logic                       load_en,
  input  logic [cpu_pkg::addr_w-1:0] load_addr,
  input  logic [cpu_pkg::data_w-1:0] load_data,
  input  cpu_pkg::mem_req_t          mem_req,
  output logic [cpu_pkg::data_w-1:0] rd_data
);
  timeunit 1ns;
  timeprecision 1ps;
  import cpu_pkg::*;

  localparam int log_w = addr_w + data_w;

  logic [data_w-1:0] cells [0:(1 << addr_w)-1];
  // Address in the upper bits, data in the lower
  logic [log_w-1:0]  wr_log [$];

  assign rd_data = cells[mem_req.address];

  always @(posedge clk) begin
    if (clear) begin
      for (int i = 0; i < (1 << addr_w); i++) begin
        cells[i] <= '0;
      end
      wr_log.delete();
    end else begin
      if (load_en) begin
        cells[load_addr] <= load_data;
      end
      if (mem_req.wr_enable) begin
        cells[mem_req.address] <= mem_req.wr_data;
        wr_log.push_back({mem_req.address, mem_req.wr_data});
      end
    end
  end

endmodule

/* verif/tb_top.sv */
// ---------------------------------------
// CPU testbench
// Loads small programs, runs the core and
// checks the writes seen on the bus
// ---------------------------------------

module tb_top;
  timeunit 1ns;
  timeprecision 1ps;
  import cpu_pkg::*;

  localparam int clk_period  = 100;
  localparam int log_w       = addr_w + data_w;
  localparam int boot_cycles = 3;
  localparam int run_margin  = 4;
  // About 40 bytes to load, 50 cycles to run and a 20 cycle halt window
  localparam int cycles_per_test = 160;
  localparam int num_tests       = 6;
  localparam int watchdog_ns     = (num_tests * cycles_per_test + 200) * clk_period;

  logic              clk = 1'b0;
  logic              resetn;
  logic              clear;
  logic              load_en;
  logic [addr_w-1:0] load_addr;
  logic [data_w-1:0] load_data;
  logic [data_w-1:0] rd_data;
  mem_req_t          mem_req;

  int                seed = 21537;
  logic [addr_w-1:0] pc_asm;
  int                run_cycles;
  logic [log_w-1:0]  exp_log [$];
  int                test_errors;
  int                err_count;
  int                tests_run;
  int                tests_passed;

  always #(clk_period / 2) clk = ~clk;

  cpu_top UUT (
    .clk     (clk),
    .resetn  (resetn),
    .rd_data (rd_data),
    .mem_req (mem_req)
  );

  tb_mem memory (
    .clk       (clk),
    .clear     (clear),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .mem_req   (mem_req),
    .rd_data   (rd_data)
  );

  // ---------------------------------------
  // Program loading
  // ---------------------------------------
  task automatic put_byte(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data);
    @(posedge clk);
    load_en   <= 1'b1;
    load_addr <= addr;
    load_data <= data;
  endtask

  // Core stays in reset while memory is cleared and loaded
  task automatic begin_test(input logic [addr_w-1:0] start);
    @(posedge clk);
    resetn <= 1'b0;
    clear  <= 1'b1;
    @(posedge clk);
    clear <= 1'b0;
    exp_log.delete();
    run_cycles  = 0;
    test_errors = 0;
    pc_asm      = start;
    put_byte(reset_vec_lo, start[7:0]);
    put_byte(reset_vec_hi, start[15:8]);
  endtask

  task automatic emit_imp(input logic [data_w-1:0] op);
    put_byte(pc_asm, op);
    pc_asm = pc_asm + 16'd1;
    run_cycles += 2;
  endtask

  task automatic emit_imm(input logic [data_w-1:0] op, input logic [data_w-1:0] val);
    put_byte(pc_asm, op);
    put_byte(pc_asm + 16'd1, val);
    pc_asm = pc_asm + 16'd2;
    run_cycles += 2;
  endtask

  task automatic emit_abs(input logic [data_w-1:0] op, input logic [addr_w-1:0] addr);
    put_byte(pc_asm, op);
    put_byte(pc_asm + 16'd1, addr[7:0]);
    put_byte(pc_asm + 16'd2, addr[15:8]);
    pc_asm = pc_asm + 16'd3;
    // JMP has no data cycle
    run_cycles += (op == op_jmp_abs) ? 3 : 4;
  endtask

  task automatic expect_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data);
    exp_log.push_back({addr, data});
  endtask

  // Release reset and wait for the program plus a few spare cycles
  task automatic launch();
    @(posedge clk);
    load_en <= 1'b0;
    repeat (3) @(posedge clk);
    resetn <= 1'b1;
    repeat (boot_cycles + run_cycles + run_margin) @(posedge clk);
    @(negedge clk);
  endtask

  // ---------------------------------------
  // Checking and reporting
  // ---------------------------------------
  task automatic note_failure();
    test_errors++;
    err_count++;
  endtask

  task automatic check_value(input string sig, input logic [15:0] exp, input logic [15:0] act);
    assert (act === exp) else begin
      $display("ERR %0t %s expected %h actual %h", $time, sig, exp, act);
      note_failure();
    end
  endtask

  task automatic check_writes();
    int n;
    n = memory.wr_log.size();
    assert (n == exp_log.size()) else begin
      if (n < exp_log.size()) begin
        $display("%0d expected write(s) never reached memory", exp_log.size() - n);
      end else begin
        $display("%0d write(s) reached memory that the program should not make",
                 n - exp_log.size());
      end
      note_failure();
    end
    for (int i = 0; i < n && i < exp_log.size(); i++) begin
      check_value($sformatf("write[%0d].address", i), 16'(exp_log[i][log_w-1:data_w]),
                  16'(memory.wr_log[i][log_w-1:data_w]));
      check_value($sformatf("write[%0d].wr_data", i), 16'(exp_log[i][data_w-1:0]),
                  16'(memory.wr_log[i][data_w-1:0]));
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errors == 0) begin
      tests_passed++;
      $display("%s: passed", name);
    end else begin
      $display("%s: failed with %0d error(s)", name, test_errors);
    end
  endtask

  // ---------------------------------------
  // Directed tests
  // ---------------------------------------
  task automatic reset_vector_loads();
    logic [addr_w-1:0] start;
    logic [addr_w-1:0] dst;
    logic [data_w-1:0] va;
    logic [data_w-1:0] vx;
    logic [data_w-1:0] vy;
    start = 16'h1000 + 16'({$random(seed)} % 32'h6000);
    dst   = 16'h8000 + 16'({$random(seed)} % 32'h1000);
    va    = 8'($random(seed));
    vx    = 8'($random(seed));
    vy    = 8'($random(seed));
    begin_test(start);
    emit_imm(op_lda_imm, va);
    emit_imm(op_ldx_imm, vx);
    emit_imm(op_ldy_imm, vy);
    emit_abs(op_sta_abs, dst);
    emit_abs(op_stx_abs, dst + 16'd1);
    emit_abs(op_sty_abs, dst + 16'd2);
    expect_write(dst, va);
    expect_write(dst + 16'd1, vx);
    expect_write(dst + 16'd2, vy);
    launch();
    check_writes();
    finish_test("reset vector and immediate loads");
  endtask

  task automatic absolute_loads();
    logic [data_w-1:0] b0;
    logic [data_w-1:0] b1;
    logic [data_w-1:0] b2;
    b0 = 8'($random(seed));
    b1 = 8'($random(seed));
    b2 = 8'($random(seed));
    begin_test(16'h0400);
    put_byte(16'h9000, b0);
    put_byte(16'h9001, b1);
    put_byte(16'h9002, b2);
    emit_abs(op_lda_abs, 16'h9000);
    emit_abs(op_sta_abs, 16'h9100);
    emit_abs(op_ldx_abs, 16'h9001);
    emit_abs(op_stx_abs, 16'h9101);
    emit_abs(op_ldy_abs, 16'h9002);
    emit_abs(op_sty_abs, 16'h9102);
    expect_write(16'h9100, b0);
    expect_write(16'h9101, b1);
    expect_write(16'h9102, b2);
    launch();
    check_writes();
    finish_test("absolute loads");
  endtask

  task automatic add_with_carry();
    logic [data_w-1:0] p;
    logic [data_w-1:0] q;
    p = 8'($random(seed));
    q = 8'($random(seed));
    begin_test(16'h0400);
    put_byte(16'ha000, q);
    put_byte(16'ha001, 8'h01);
    put_byte(16'ha002, 8'h00);
    emit_imp(op_clc);
    emit_imm(op_lda_imm, p);
    emit_abs(op_adc_abs, 16'ha000);
    emit_abs(op_sta_abs, 16'ha100);
    emit_imp(op_sec);
    emit_imm(op_lda_imm, p);
    emit_abs(op_adc_abs, 16'ha000);
    emit_abs(op_sta_abs, 16'ha101);
    // FF + 01 leaves zero with carry set, then 0 + 0 + carry
    emit_imp(op_clc);
    emit_imm(op_lda_imm, 8'hff);
    emit_abs(op_adc_abs, 16'ha001);
    emit_abs(op_adc_abs, 16'ha002);
    emit_abs(op_sta_abs, 16'ha102);
    expect_write(16'ha100, 8'(p + q));
    expect_write(16'ha101, 8'(p + q + 8'd1));
    expect_write(16'ha102, 8'h01);
    launch();
    check_writes();
    finish_test("add with carry");
  endtask

  task automatic logic_ops();
    logic [data_w-1:0] p;
    logic [data_w-1:0] q;
    logic [data_w-1:0] r;
    p = 8'($random(seed));
    q = 8'($random(seed));
    r = 8'($random(seed));
    begin_test(16'h0400);
    put_byte(16'hb000, q);
    put_byte(16'hb001, 8'h00);
    emit_imp(op_sec);
    emit_imm(op_lda_imm, p);
    emit_abs(op_and_abs, 16'hb000);
    emit_abs(op_sta_abs, 16'hb100);
    emit_imm(op_lda_imm, p);
    emit_abs(op_ora_abs, 16'hb000);
    emit_abs(op_sta_abs, 16'hb101);
    emit_imm(op_lda_imm, p);
    emit_abs(op_eor_abs, 16'hb000);
    emit_abs(op_sta_abs, 16'hb102);
    // Carry from SEC must survive the logic ops
    emit_imm(op_lda_imm, r);
    emit_abs(op_adc_abs, 16'hb001);
    emit_abs(op_sta_abs, 16'hb103);
    expect_write(16'hb100, p & q);
    expect_write(16'hb101, p | q);
    expect_write(16'hb102, p ^ q);
    expect_write(16'hb103, 8'(r + 8'd1));
    launch();
    check_writes();
    finish_test("logic operations");
  endtask

  task automatic jump_over_store();
    logic [addr_w-1:0] target;
    logic [data_w-1:0] v;
    target = 16'h0500 + 16'({$random(seed)} % 32'h0100);
    v      = 8'($random(seed));
    begin_test(16'h0400);
    emit_imm(op_lda_imm, v);
    emit_abs(op_jmp_abs, target);
    emit_abs(op_sta_abs, 16'hc000);
    pc_asm = target;
    emit_abs(op_sta_abs, 16'hc001);
    expect_write(16'hc001, v);
    launch();
    check_writes();
    finish_test("jump");
  endtask

  task automatic halt_on_illegal();
    logic [data_w-1:0] v;
    logic [addr_w-1:0] frozen;
    v = 8'($random(seed));
    begin_test(16'h0400);
    emit_imm(op_lda_imm, v);
    emit_abs(op_sta_abs, 16'hd000);
    // Illegal opcode, then a store that must never run
    put_byte(pc_asm, 8'hff);
    pc_asm = pc_asm + 16'd1;
    run_cycles += 2;
    emit_abs(op_sta_abs, 16'hd001);
    expect_write(16'hd000, v);
    launch();
    frozen = mem_req.address;
    for (int i = 0; i < 20; i++) begin
      @(negedge clk);
      check_value("mem_req.address", frozen, mem_req.address);
      assert (!mem_req.wr_enable) else begin
        $display("wr_enable went high at %0t while the core was halted", $time);
        note_failure();
      end
    end
    check_writes();
    finish_test("halt");
  endtask

  // ---------------------------------------
  // Main sequence and watchdog
  // ---------------------------------------
  initial begin
    resetn       <= 1'b0;
    clear        <= 1'b0;
    load_en      <= 1'b0;
    load_addr    <= '0;
    load_data    <= '0;
    err_count    = 0;
    tests_run    = 0;
    tests_passed = 0;
    reset_vector_loads();
    absolute_loads();
    add_with_carry();
    logic_ops();
    jump_over_store();
    halt_on_illegal();
    $display("tests run %0d, passed %0d, failed %0d, failed checks %0d",
             tests_run, tests_passed, tests_run - tests_passed, err_count);
    if (err_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin
    #(watchdog_ns);
    $display("Watchdog expired before all tests finished");
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

/* list.f */
common/cpu_pkg.sv
src/alu.sv
core/opcode_decoder.sv
core/reg_bank.sv
core/sequencer.sv
src/cpu_top.sv
verif/tb_mem.sv
verif/tb_top.sv

/* run.sh */
#!/bin/sh
# Build the CPU testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module tb_top -f list.f -o sim_tb
./obj_dir/sim_tb | tee sim.log
if grep -q "STATUS: PASS" sim.log; then
  exit 0
fi
exit 1
